// ==== src/clock_ctrl_pkg.sv ====
package clock_ctrl_pkg;

    localparam logic [6:0] RTC_ADDR        = 7'h68;
    localparam logic [7:0] RTC_REG_SECONDS = 8'h00;
    localparam logic [7:0] RTC_READ_BYTES  = 8'd3;  // seconds, minutes and hours.
    localparam logic [7:0] START_BYTE      = 8'hAA;
    localparam logic [7:0] DIGIT_ADDR_BASE = 8'hC0;

    typedef enum logic [7:0] {
        ANSWER_OK     = 8'hAA,
        ANSWER_REPEAT = 8'hBB
    } answer_code_t;

    typedef struct packed {
        logic [7:0] hr;
        logic [7:0] min;
        logic [7:0] sec;
    } time_bcd_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } host_byte_t;

    typedef struct packed {
        logic       en;        // pulses for one cycle to start a transfer.
        logic       rw;
        logic [6:0] addr;
        logic [7:0] byte_read;
        logic       in_valid;  // pulses for one cycle per data byte.
        logic [7:0] in_data;
    } i2c_cmd_t;

    typedef struct packed {
        logic       in_ready;
        logic       out_valid;
        logic [7:0] out_data;
    } i2c_rsp_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } disp_byte_t;

    typedef enum logic [2:0] {
        PS_IDLE,
        PS_START,
        PS_HR,
        PS_MIN,
        PS_SEC,
        PS_ANSWER
    } parser_state_t;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_SEND,
        RS_WAIT,
        RS_READ
    } rtc_state_t;

    typedef enum logic [2:0] {
        DS_IDLE,
        DS_ADDR,
        DS_ADDR_GAP,
        DS_DATA,
        DS_DATA_GAP
    } disp_state_t;

    // segment order is gfedcba, the decimal point (bit 7) stays dark.
    function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
        case (digit)
            4'd0: return 8'h3F;
            4'd1: return 8'h06;
            4'd2: return 8'h5B;
            4'd3: return 8'h4F;
            4'd4: return 8'h66;
            4'd5: return 8'h6D;
            4'd6: return 8'h7D;
            4'd7: return 8'h07;
            4'd8: return 8'h7F;
            4'd9: return 8'h6F;
            default: return 8'h00;
        endcase
    endfunction

endpackage

// ==== src/time_set_parser.sv ====
`timescale 1ns/1ps

module time_set_parser (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      packet,
    input  clock_ctrl_pkg::host_byte_t host_in,
    input  logic                      answer_ready,
    output logic                      host_ready,
    output clock_ctrl_pkg::host_byte_t answer,
    output logic                      time_set,
    output clock_ctrl_pkg::time_bcd_t  new_time
);
    import clock_ctrl_pkg::*;

    parser_state_t state;
    answer_code_t  code;
    logic [7:0]    rx_hr;
    logic [7:0]    rx_min;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= PS_IDLE;
            code         <= ANSWER_REPEAT;
            host_ready   <= 1'b0;
            time_set     <= 1'b0;
            answer.valid <= 1'b0;
        end else begin
            host_ready   <= 1'b0;
            time_set     <= 1'b0;
            answer.valid <= 1'b0;
            case (state)
                PS_IDLE: begin
                    if (packet)
                        state <= PS_START;
                end
                PS_START: begin
                    if (host_in.valid) begin
                        host_ready <= 1'b1;
                        if (host_in.data == START_BYTE) begin
                            state <= PS_HR;
                        end else begin
                            code  <= ANSWER_REPEAT;  // answered at once, nothing is drained.
                            state <= PS_ANSWER;
                        end
                    end
                end
                PS_HR: begin
                    if (host_in.valid) begin
                        host_ready <= 1'b1;
                        state      <= PS_MIN;
                    end
                end
                PS_MIN: begin
                    if (host_in.valid) begin
                        host_ready <= 1'b1;
                        state      <= PS_SEC;
                    end
                end
                PS_SEC: begin
                    if (host_in.valid) begin
                        host_ready <= 1'b1;
                        time_set   <= 1'b1;
                        code       <= ANSWER_OK;
                        state      <= PS_ANSWER;
                    end
                end
                PS_ANSWER: begin
                    if (answer_ready) begin
                        answer.valid <= 1'b1;
                        answer.data  <= code;
                        state        <= PS_IDLE;
                    end
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    // new_time only moves together with the time_set pulse.
    always_ff @(posedge clk) begin
        if (state == PS_HR && host_in.valid)
            rx_hr <= host_in.data;
        if (state == PS_MIN && host_in.valid)
            rx_min <= host_in.data;
        if (state == PS_SEC && host_in.valid)
            new_time <= '{hr: rx_hr, min: rx_min, sec: host_in.data};
    end

    a_answer_single : assert property (@(posedge clk) disable iff (reset)
        answer.valid |=> !answer.valid);

endmodule

// ==== src/rtc_sequencer.sv ====
`timescale 1ns/1ps

module rtc_sequencer #(
    parameter int READ_PERIOD_CYCLES = 1 << 20
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     time_set,
    input  clock_ctrl_pkg::time_bcd_t new_time,
    input  clock_ctrl_pkg::i2c_rsp_t  i2c_rsp,
    output clock_ctrl_pkg::i2c_cmd_t  i2c_cmd,
    output logic                     time_valid,
    output clock_ctrl_pkg::time_bcd_t rtc_time
);
    import clock_ctrl_pkg::*;

    localparam int TIMER_W = $clog2(READ_PERIOD_CYCLES + 1);

    rtc_state_t         state;
    logic [2:0]         step;       // byte index inside the transaction.
    logic               is_read;
    logic               pending;
    logic [1:0]         rd_cnt;
    logic [TIMER_W-1:0] read_timer;
    logic               read_due;
    logic               start_write;
    time_bcd_t          wr_time;

    assign read_due    = read_timer == TIMER_W'(READ_PERIOD_CYCLES);
    assign start_write = state == RS_IDLE && pending;

    // the timer starts out expired so the first read follows reset.
    always_ff @(posedge clk) begin
        if (reset)
            read_timer <= TIMER_W'(READ_PERIOD_CYCLES);
        else if (state != RS_IDLE)
            read_timer <= '0;
        else if (!read_due)
            read_timer <= read_timer + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset)
            pending <= 1'b0;
        else if (time_set)
            pending <= 1'b1;  // a new time wins over the clear.
        else if (start_write)
            pending <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= RS_IDLE;
            step       <= '0;
            is_read    <= 1'b0;
            rd_cnt     <= '0;
            time_valid <= 1'b0;
            i2c_cmd    <= '0;
        end else begin
            i2c_cmd.en       <= 1'b0;
            i2c_cmd.in_valid <= 1'b0;
            time_valid       <= 1'b0;
            case (state)
                RS_IDLE: begin
                    i2c_cmd.rw   <= 1'b0;
                    i2c_cmd.addr <= '0;
                    step         <= '0;
                    if (pending || read_due) begin
                        is_read <= !pending;  // a pending write goes first.
                        state   <= RS_SEND;
                    end
                end
                RS_SEND: begin
                    if (i2c_rsp.in_ready) begin
                        state <= RS_WAIT;
                        case (step)
                            3'd0: begin
                                i2c_cmd.en        <= 1'b1;
                                i2c_cmd.rw        <= 1'b0;
                                i2c_cmd.addr      <= RTC_ADDR;
                                i2c_cmd.byte_read <= '0;
                            end
                            3'd1: begin
                                i2c_cmd.in_valid <= 1'b1;
                                i2c_cmd.in_data  <= RTC_REG_SECONDS;
                            end
                            3'd2: begin
                                if (is_read) begin
                                    i2c_cmd.en        <= 1'b1;
                                    i2c_cmd.rw        <= 1'b1;
                                    i2c_cmd.byte_read <= RTC_READ_BYTES;
                                    rd_cnt            <= '0;
                                    state             <= RS_READ;
                                end else begin
                                    i2c_cmd.in_valid <= 1'b1;
                                    i2c_cmd.in_data  <= wr_time.sec;
                                end
                            end
                            3'd3: begin
                                i2c_cmd.in_valid <= 1'b1;
                                i2c_cmd.in_data  <= wr_time.min;
                            end
                            default: begin
                                i2c_cmd.in_valid <= 1'b1;
                                i2c_cmd.in_data  <= wr_time.hr;
                            end
                        endcase
                    end
                end
                RS_WAIT: begin
                    if (!i2c_rsp.in_ready) begin
                        if (step == 3'd4) begin
                            state <= RS_IDLE;
                        end else begin
                            step  <= step + 1'b1;
                            state <= RS_SEND;
                        end
                    end
                end
                RS_READ: begin
                    if (i2c_rsp.out_valid) begin
                        rd_cnt <= rd_cnt + 1'b1;
                        if (rd_cnt == 2'd2) begin
                            time_valid <= 1'b1;
                            state      <= RS_IDLE;
                        end
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_write)
            wr_time <= new_time;
        if (state == RS_READ && i2c_rsp.out_valid) begin
            case (rd_cnt)
                2'd0: rtc_time.sec <= i2c_rsp.out_data;
                2'd1: rtc_time.min <= i2c_rsp.out_data;
                default: rtc_time.hr <= i2c_rsp.out_data;
            endcase
        end
    end

    a_cmd_exclusive : assert property (@(posedge clk) disable iff (reset)
        !(i2c_cmd.en && i2c_cmd.in_valid));

endmodule

// ==== src/display_writer.sv ====
`timescale 1ns/1ps

module display_writer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      time_valid,
    input  clock_ctrl_pkg::time_bcd_t  rtc_time,
    input  logic                      display_ready,
    output clock_ctrl_pkg::disp_byte_t disp
);
    import clock_ctrl_pkg::*;

    disp_state_t state;
    logic [1:0]  pos;      // digit position, hour tens first.
    logic [15:0] digits;   // latched hr and min in BCD.
    logic [3:0]  nibble;

    assign nibble = digits[4 * (3 - pos) +: 4];

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= DS_IDLE;
            pos        <= '0;
            disp.valid <= 1'b0;
        end else begin
            disp.valid <= 1'b0;
            case (state)
                DS_IDLE: begin
                    pos <= '0;
                    if (time_valid)
                        state <= DS_ADDR;
                end
                DS_ADDR: begin
                    if (display_ready) begin
                        disp.valid <= 1'b1;
                        disp.data  <= DIGIT_ADDR_BASE + 8'(pos);
                        state      <= DS_ADDR_GAP;
                    end
                end
                DS_ADDR_GAP: state <= DS_DATA;
                DS_DATA: begin
                    if (display_ready) begin
                        disp.valid <= 1'b1;
                        disp.data  <= seg_pattern(nibble);
                        state      <= DS_DATA_GAP;
                    end
                end
                DS_DATA_GAP: begin
                    if (pos == 2'd3) begin
                        state <= DS_IDLE;
                    end else begin
                        pos   <= pos + 1'b1;
                        state <= DS_ADDR;
                    end
                end
                default: state <= DS_IDLE;
            endcase
        end
    end

    // the time is taken only when a burst starts.
    always_ff @(posedge clk) begin
        if (state == DS_IDLE && time_valid)
            digits <= {rtc_time.hr, rtc_time.min};
    end

    a_disp_single : assert property (@(posedge clk) disable iff (reset)
        disp.valid |=> !disp.valid);

endmodule

// ==== src/hour_chime.sv ====
`timescale 1ns/1ps

module hour_chime #(
    parameter int CHIME_CYCLES = 1 << 20
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       time_valid,
    input  logic [7:0] hr,
    output logic       buzz_en
);
    localparam int COUNT_W = $clog2(CHIME_CYCLES + 1);

    logic [7:0]         last_hr;
    logic [COUNT_W-1:0] count;
    logic               hour_changed;

    assign hour_changed = time_valid && hr != last_hr;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hr <= 8'h00;
            count   <= '0;
            buzz_en <= 1'b0;
        end else if (hour_changed) begin
            last_hr <= hr;
            count   <= COUNT_W'(CHIME_CYCLES - 1);  // restarts a running chime.
            buzz_en <= 1'b1;
        end else if (buzz_en) begin
            if (count == '0)
                buzz_en <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

endmodule

// ==== src/clock_ctrl_top.sv ====
`timescale 1ns/1ps

module clock_ctrl_top #(
    parameter int READ_PERIOD_CYCLES = 1 << 20,
    parameter int CHIME_CYCLES       = 1 << 20
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      packet,
    input  clock_ctrl_pkg::host_byte_t host_in,
    output logic                      host_ready,
    output clock_ctrl_pkg::host_byte_t answer,
    input  logic                      answer_ready,
    output clock_ctrl_pkg::i2c_cmd_t   i2c_cmd,
    input  clock_ctrl_pkg::i2c_rsp_t   i2c_rsp,
    output clock_ctrl_pkg::disp_byte_t disp,
    input  logic                      display_ready,
    output logic                      buzz_en
);
    import clock_ctrl_pkg::*;

    logic      time_set;
    time_bcd_t new_time;
    logic      time_valid;
    time_bcd_t rtc_time;

    time_set_parser u_parser (
        .clk          (clk),
        .reset        (reset),
        .packet       (packet),
        .host_in      (host_in),
        .answer_ready (answer_ready),
        .host_ready   (host_ready),
        .answer       (answer),
        .time_set     (time_set),
        .new_time     (new_time)
    );

    rtc_sequencer #(
        .READ_PERIOD_CYCLES (READ_PERIOD_CYCLES)
    ) u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .time_set   (time_set),
        .new_time   (new_time),
        .i2c_rsp    (i2c_rsp),
        .i2c_cmd    (i2c_cmd),
        .time_valid (time_valid),
        .rtc_time   (rtc_time)
    );

    display_writer u_display (
        .clk           (clk),
        .reset         (reset),
        .time_valid    (time_valid),
        .rtc_time      (rtc_time),
        .display_ready (display_ready),
        .disp          (disp)
    );

    hour_chime #(
        .CHIME_CYCLES (CHIME_CYCLES)
    ) u_chime (
        .clk        (clk),
        .reset      (reset),
        .time_valid (time_valid),
        .hr         (rtc_time.hr),
        .buzz_en    (buzz_en)
    );

endmodule

// ==== bench/tb_clock_ctrl.sv ====
`timescale 1ns/1ps

module tb_clock_ctrl;
    import clock_ctrl_pkg::*;

    localparam int READ_PERIOD = 300;
    localparam int CHIME_LEN   = 40;
    localparam int MAX_BUSY    = 4;  // longest in_ready drop of the I2C model.
    localparam int SLACK       = 4;  // sequencer pipeline between timer expiry and en.

    // segment patterns of the digits 0 to 9 in gfedcba order.
    localparam logic [7:0] SEG_TABLE[10] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F
    };

    typedef struct packed {
        logic       is_set;
        logic [7:0] start;
        time_bcd_t  host;
        time_bcd_t  rtc;
    } stim_rec_t;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       packet;
    host_byte_t host_in;
    logic       host_ready;
    host_byte_t answer;
    logic       answer_ready;
    i2c_cmd_t   i2c_cmd;
    i2c_rsp_t   i2c_rsp = '{in_ready: 1'b1, out_valid: 1'b0, out_data: 8'h00};
    disp_byte_t disp;
    logic       display_ready = 1'b0;
    logic       buzz_en;

    integer      seed = 32'h54b0_ed5e;
    int          cyc = 0;
    int          timeout_cycles = 1000;
    int          busy = 0;
    int          read_left = 0;
    int          reads_done = 0;
    int          read_done_cyc = 0;
    int          prev_end = -1;
    logic [7:0]  last_hr = 8'h00;
    time_bcd_t   cur_rtc;
    logic [19:0] i2c_log[$];
    int          i2c_log_cyc[$];
    logic [7:0]  disp_log[$];
    stim_rec_t   recs[$];

    clock_ctrl_top #(
        .READ_PERIOD_CYCLES (READ_PERIOD),
        .CHIME_CYCLES       (CHIME_LEN)
    ) u_dut (
        .clk           (clk),
        .reset         (reset),
        .packet        (packet),
        .host_in       (host_in),
        .host_ready    (host_ready),
        .answer        (answer),
        .answer_ready  (answer_ready),
        .i2c_cmd       (i2c_cmd),
        .i2c_rsp       (i2c_rsp),
        .disp          (disp),
        .display_ready (display_ready),
        .buzz_en       (buzz_en)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("timeout, the test did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    // I2C master and display driver models, both answer on the falling edge.
    always @(negedge clk) begin
        logic [31:0] rnd;
        logic [19:0] ev;
        rnd = $random(seed);
        if (disp.valid) begin
            // display_ready still holds the level the DUT sampled for this byte.
            assert (display_ready) else begin
                $display("display byte sent while display_ready was low");
                abort_run();
            end
            disp_log.push_back(disp.data);
        end
        display_ready = rnd[0];
        i2c_rsp.out_valid = 1'b0;
        if (i2c_cmd.en || i2c_cmd.in_valid) begin
            assert (i2c_rsp.in_ready) else begin
                $display("I2C command issued while in_ready was low");
                abort_run();
            end
            if (i2c_cmd.en)
                ev = {i2c_cmd.rw ? 4'h2 : 4'h1, 1'b0, i2c_cmd.addr,
                      i2c_cmd.rw ? i2c_cmd.byte_read : 8'h00};
            else
                ev = {4'h3, 8'h00, i2c_cmd.in_data};
            i2c_log.push_back(ev);
            i2c_log_cyc.push_back(cyc);
            i2c_rsp.in_ready = 1'b0;
            busy = int'(rnd[2:1]);  // in_ready stays low 1 to 4 cycles.
            if (i2c_cmd.en && i2c_cmd.rw)
                read_left = 3;
        end else if (busy > 0) begin
            busy = busy - 1;
        end else if (read_left > 0) begin
            i2c_rsp.out_valid = 1'b1;
            case (read_left)
                3: i2c_rsp.out_data = cur_rtc.sec;
                2: i2c_rsp.out_data = cur_rtc.min;
                default: i2c_rsp.out_data = cur_rtc.hr;
            endcase
            read_left = read_left - 1;
            busy = 1;
            if (read_left == 0) begin
                read_done_cyc = cyc;
                reads_done = reads_done + 1;
            end
        end else begin
            i2c_rsp.in_ready = 1'b1;
        end
    end

    function automatic logic [7:0] segments(input logic [3:0] digit);
        return (digit <= 4'd9) ? SEG_TABLE[int'(digit)] : 8'h00;
    endfunction

    function automatic logic [19:0] start_event(input logic rw);
        return {rw ? 4'h2 : 4'h1, 1'b0, 7'h68, rw ? 8'd3 : 8'h00};
    endfunction

    function automatic logic [19:0] data_event(input logic [7:0] value);
        return {4'h3, 8'h00, value};
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_event(input logic [19:0] exp, input string name, output int at);
        logic [19:0] ev;
        while (i2c_log.size() == 0)
            @(negedge clk);
        ev = i2c_log.pop_front();
        at = i2c_log_cyc.pop_front();
        check_value(name, 32'(ev), 32'(exp));
    endtask

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] kind;
        logic [7:0]  b[7];
        stim_rec_t   rec;
        fd = $fopen("bench/clock_ctrl_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/clock_ctrl_stim.txt");
            abort_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h", kind,
                            b[0], b[1], b[2], b[3], b[4], b[5], b[6]);
                if (n != 8 || (kind != 32'("set") && kind != 32'("read"))) begin
                    $display("malformed stim line: %s", line);
                    abort_run();
                end
                rec.is_set   = kind == 32'("set");
                rec.start    = b[0];
                rec.host.hr  = b[1];
                rec.host.min = b[2];
                rec.host.sec = b[3];
                rec.rtc.sec  = b[4];
                rec.rtc.min  = b[5];
                rec.rtc.hr   = b[6];
                recs.push_back(rec);
            end
        end
        $fclose(fd);
    endtask

    task automatic send_packet(input stim_rec_t rec);
        logic [7:0] bytes[4];
        int         n;
        bytes = '{rec.start, rec.host.hr, rec.host.min, rec.host.sec};
        n = (rec.start == START_BYTE) ? 4 : 1;  // a bad start byte ends the packet.
        packet = 1'b1;
        @(negedge clk);
        packet = 1'b0;
        for (int i = 0; i < n; i++) begin
            host_in = '{valid: 1'b1, data: bytes[i]};
            @(negedge clk);
            check_value("host_ready", 32'(host_ready), 32'd1);
            host_in.valid = 1'b0;
            @(negedge clk);
            check_value("host_ready", 32'(host_ready), 32'd0);
        end
        repeat (2) begin
            check_value("answer.valid", 32'(answer.valid), 32'd0);
            @(negedge clk);
        end
        answer_ready = 1'b1;
        @(negedge clk);
        answer_ready = 1'b0;
        check_value("answer.valid", 32'(answer.valid), 32'd1);
        check_value("answer.data", 32'(answer.data),
                    (rec.start == START_BYTE) ? 32'h0000_00AA : 32'h0000_00BB);
        @(negedge clk);
        check_value("answer.valid", 32'(answer.valid), 32'd0);
    endtask

    task automatic check_chime(input logic changed);
        while (cyc < read_done_cyc + 1)
            @(negedge clk);
        check_value("buzz_en", 32'(buzz_en), 32'd0);
        @(negedge clk);
        check_value("buzz_en", 32'(buzz_en), 32'(changed));
        if (changed) begin
            repeat (CHIME_LEN - 1) begin
                @(negedge clk);
                check_value("buzz_en", 32'(buzz_en), 32'd1);
            end
            @(negedge clk);
            check_value("buzz_en", 32'(buzz_en), 32'd0);
        end
    endtask

    task automatic check_display(input time_bcd_t t);
        logic [7:0] exp[8];
        logic [7:0] got;
        exp = '{8'hC0, segments(t.hr[7:4]), 8'hC1, segments(t.hr[3:0]),
                8'hC2, segments(t.min[7:4]), 8'hC3, segments(t.min[3:0])};
        for (int i = 0; i < 8; i++) begin
            while (disp_log.size() == 0)
                @(negedge clk);
            got = disp_log.pop_front();
            check_value("disp.data", 32'(got), 32'(exp[i]));
        end
    endtask

    task automatic run_record(input stim_rec_t rec, input int index);
        int at;
        int read_at;
        int gap;
        cur_rtc = rec.rtc;
        if (rec.is_set) begin
            send_packet(rec);
            if (rec.start == START_BYTE) begin
                next_event(start_event(1'b0), "i2c_cmd write start", at);
                next_event(data_event(8'h00), "i2c_cmd.in_data reg", at);
                next_event(data_event(rec.host.sec), "i2c_cmd.in_data sec", at);
                next_event(data_event(rec.host.min), "i2c_cmd.in_data min", at);
                next_event(data_event(rec.host.hr), "i2c_cmd.in_data hr", at);
                prev_end = at;
            end
        end
        next_event(start_event(1'b0), "i2c_cmd read start", read_at);
        if (prev_end >= 0) begin
            gap = read_at - prev_end;
            assert (gap >= READ_PERIOD && gap <= READ_PERIOD + MAX_BUSY + SLACK) else begin
                $display("read started %0d cycles after the previous transaction", gap);
                abort_run();
            end
        end
        next_event(data_event(8'h00), "i2c_cmd.in_data reg", at);
        next_event(start_event(1'b1), "i2c_cmd read restart", at);
        while (reads_done <= index)
            @(negedge clk);
        prev_end = read_done_cyc;
        check_chime(rec.rtc.hr != last_hr);
        last_hr = rec.rtc.hr;
        check_display(rec.rtc);
    endtask

    initial begin
        packet = 1'b0;
        host_in = '0;
        answer_ready = 1'b0;
        load_stim();
        timeout_cycles = recs.size() * 1000 + READ_PERIOD;
        cur_rtc = recs[0].rtc;
        repeat (3) @(negedge clk);
        check_value("answer.valid", 32'(answer.valid), 32'd0);
        check_value("host_ready", 32'(host_ready), 32'd0);
        check_value("i2c_cmd.en", 32'(i2c_cmd.en), 32'd0);
        check_value("i2c_cmd.in_valid", 32'(i2c_cmd.in_valid), 32'd0);
        check_value("i2c_cmd.rw", 32'(i2c_cmd.rw), 32'd0);
        check_value("i2c_cmd.addr", 32'(i2c_cmd.addr), 32'd0);
        check_value("disp.valid", 32'(disp.valid), 32'd0);
        check_value("buzz_en", 32'(buzz_en), 32'd0);
        reset = 1'b0;
        foreach (recs[i])
            run_record(recs[i], i);
        repeat (20) @(negedge clk);
        assert (disp_log.size() == 0 && i2c_log.size() == 0) else begin
            $display("extra display or I2C bytes appeared after the last record");
            abort_run();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== bench/clock_ctrl_stim.txt ====
# kind start hr min sec rtc_sec rtc_min rtc_hr, all values hex, times in BCD
# set sends the host packet before the read, read leaves the host idle
read 00 00 00 00 15 00 00
read 00 00 00 00 16 59 09
read 00 00 00 00 17 59 09
set  AA 10 30 45 45 30 10
set  55 11 22 33 05 31 10
set  AA 23 59 58 58 59 23
read 00 00 00 00 01 00 00
set  AB 12 00 00 02 00 00
set  AA 07 45 12 13 45 07
read 00 00 00 00 48 37 18
set  AA 19 04 26 27 04 19
set  BB 01 02 03 28 04 19
read 00 00 00 00 30 16 21
set  AA 06 08 50 51 08 06

// ==== filelist.f ====
src/clock_ctrl_pkg.sv
src/time_set_parser.sv
src/rtc_sequencer.sv
src/display_writer.sv
src/hour_chime.sv
src/clock_ctrl_top.sv
bench/tb_clock_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_clock_ctrl -f filelist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_clock_ctrl)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^PASS: all tests$"; then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1
